/* fc_irq.f */
logic/apb_defs_pkg.sv
logic/irq_defs_pkg.sv
logic/irq_reg_frontend.sv
logic/irq_source_slice.sv
logic/irq_priority_tree.sv
logic/soc_event_to_level.sv
logic/fc_irq_top.sv
verification/fc_irq_props.sv
verification/fc_irq_tb.sv

/* logic/apb_defs_pkg.sv */
package apb_defs_pkg;

    // Bus widths of the APB slave port
    typedef logic [11:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    //************************************************************************
    //***** Register map *****************************************************
    //************************************************************************

    // Slice i lives at REG_SRC_BASE + 4*i
    localparam apb_addr_t REG_SRC_BASE   = 12'h000;

    // Event converter registers
    localparam apb_addr_t REG_EVT_STATUS = 12'h080;
    localparam apb_addr_t REG_EVT_CLEAR  = 12'h084;

    // Setup phase is spent in APB_IDLE, the access phase in APB_ACCESS
    typedef enum logic {
        APB_IDLE,
        APB_ACCESS
    } apb_state_t;

endpackage

/* logic/fc_irq_top.sv */
module fc_irq_top
    import apb_defs_pkg::*;
    import irq_defs_pkg::*;
(
    input  logic               clk_i,
    input  logic               rst_i,

    // APB slave
    input  apb_addr_t          paddr_i,
    input  logic               psel_i,
    input  logic               penable_i,
    input  logic               pwrite_i,
    input  apb_data_t          pwdata_i,
    output apb_data_t          prdata_o,
    output logic               pready_o,
    output logic               pslverr_o,

    // Level sources, the EVT_SRC bit is replaced by the event converter
    input  logic [NUM_SRC-1:0] irq_src_i,

    // SoC event stream
    input  logic               evt_valid_i,
    input  evt_id_t            evt_data_i,
    output logic               evt_ready_o,

    // Core handshake
    output logic               irq_valid_o,
    output irq_id_t            irq_id_o,
    output irq_level_t         irq_level_o,
    input  logic               irq_ack_i
);

    apb_data_t  [NUM_SRC-1:0] src_rdata;
    logic       [NUM_SRC-1:0] src_we;
    logic       [NUM_SRC-1:0] src_req;
    logic       [NUM_SRC-1:0] src_claim;
    irq_level_t [NUM_SRC-1:0] src_level;
    apb_data_t                cfg_wdata;
    apb_data_t                evt_status;
    logic                     evt_clear;
    logic                     evt_level;

    //************************************************************************
    //***** Register front end ***********************************************
    //************************************************************************

    irq_reg_frontend i_frontend (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .paddr_i      (paddr_i),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .pwdata_i     (pwdata_i),
        .prdata_o     (prdata_o),
        .pready_o     (pready_o),
        .pslverr_o    (pslverr_o),
        .src_rdata_i  (src_rdata),
        .evt_status_i (evt_status),
        .src_we_o     (src_we),
        .wdata_o      (cfg_wdata),
        .evt_clear_o  (evt_clear)
    );

    //************************************************************************
    //***** Source slices ****************************************************
    //************************************************************************

    for (genvar i = 0; i < NUM_SRC; i++) begin : gen_src
        irq_source_slice i_slice (
            .clk_i       (clk_i),
            .rst_i       (rst_i),
            .src_i       ((i == EVT_SRC) ? evt_level : irq_src_i[i]),
            .cfg_we_i    (src_we[i]),
            .cfg_wdata_i (cfg_wdata),
            .cfg_rdata_o (src_rdata[i]),
            .claim_i     (src_claim[i]),
            .req_o       (src_req[i]),
            .level_o     (src_level[i])
        );
    end

    irq_priority_tree i_tree (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_i       (src_req),
        .level_i     (src_level),
        .claim_o     (src_claim),
        .irq_valid_o (irq_valid_o),
        .irq_id_o    (irq_id_o),
        .irq_level_o (irq_level_o),
        .irq_ack_i   (irq_ack_i)
    );

    // SoC events become a level on source EVT_SRC
    soc_event_to_level i_evt (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .evt_valid_i (evt_valid_i),
        .evt_data_i  (evt_data_i),
        .evt_ready_o (evt_ready_o),
        .clear_i     (evt_clear),
        .status_o    (evt_status),
        .level_o     (evt_level)
    );

endmodule

/* logic/irq_defs_pkg.sv */
package irq_defs_pkg;

    //************************************************************************
    //***** Interrupt source configuration ***********************************
    //************************************************************************

    // Number of level sources seen by the priority tree
    localparam int NUM_SRC = 16;

    // Source slot that is fed by the SoC event converter
    localparam int EVT_SRC = 5;

    // Source identifier, wide enough to index every slice
    typedef logic [$clog2(NUM_SRC)-1:0] irq_id_t;

    // Priority level, higher value wins
    typedef logic [7:0] irq_level_t;

    // SoC event identifier as delivered by the event stream
    typedef logic [7:0] evt_id_t;

endpackage

/* logic/irq_priority_tree.sv */
module irq_priority_tree
    import irq_defs_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     rst_i,

    // Slice side
    input  logic       [NUM_SRC-1:0] req_i,
    input  irq_level_t [NUM_SRC-1:0] level_i,
    output logic       [NUM_SRC-1:0] claim_o,

    // Core handshake
    output logic                     irq_valid_o,
    output irq_id_t                  irq_id_o,
    output irq_level_t               irq_level_o,
    input  logic                     irq_ack_i
);

    // Heap ordered nodes, the leaves start at index NUM_SRC-1
    logic       node_vld [2*NUM_SRC-1];
    irq_level_t node_lvl [2*NUM_SRC-1];
    irq_id_t    node_id  [2*NUM_SRC-1];

    logic       valid_q;
    irq_id_t    id_q;
    irq_level_t level_q;

    //************************************************************************
    //***** Comparison tree **************************************************
    //************************************************************************

    always_comb begin
        for (int i = 0; i < NUM_SRC; i++) begin
            node_vld[NUM_SRC-1+i] = req_i[i];
            node_lvl[NUM_SRC-1+i] = level_i[i];
            node_id[NUM_SRC-1+i]  = irq_id_t'(i);
        end
        // Left child holds the lower identifiers, so it keeps ties
        for (int n = NUM_SRC - 2; n >= 0; n--) begin
            if (node_vld[2*n+2] &&
                (!node_vld[2*n+1] || (node_lvl[2*n+2] > node_lvl[2*n+1]))) begin
                node_vld[n] = 1'b1;
                node_lvl[n] = node_lvl[2*n+2];
                node_id[n]  = node_id[2*n+2];
            end else begin
                node_vld[n] = node_vld[2*n+1];
                node_lvl[n] = node_lvl[2*n+1];
                node_id[n]  = node_id[2*n+1];
            end
        end
    end

    //************************************************************************
    //***** Registered request ***********************************************
    //************************************************************************

    // Valid drops for one cycle after an ack so the claimed slice can clear
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else if (valid_q) begin
            if (irq_ack_i) begin
                valid_q <= 1'b0;
            end
        end else begin
            valid_q <= node_vld[0];
        end
    end

    // Winner is frozen while the request is outstanding
    always_ff @(posedge clk_i) begin
        if (!valid_q) begin
            id_q    <= node_id[0];
            level_q <= node_lvl[0];
        end
    end

    always_comb begin
        claim_o = '0;
        if (valid_q && irq_ack_i) begin
            claim_o[id_q] = 1'b1;
        end
    end

    assign irq_valid_o = valid_q;
    assign irq_id_o    = id_q;
    assign irq_level_o = level_q;

endmodule

/* logic/irq_reg_frontend.sv */
module irq_reg_frontend
    import apb_defs_pkg::*;
    import irq_defs_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    rst_i,

    // APB slave
    input  apb_addr_t               paddr_i,
    input  logic                    psel_i,
    input  logic                    penable_i,
    input  logic                    pwrite_i,
    input  apb_data_t               pwdata_i,
    output apb_data_t               prdata_o,
    output logic                    pready_o,
    output logic                    pslverr_o,

    // Register side
    input  apb_data_t [NUM_SRC-1:0] src_rdata_i,
    input  apb_data_t               evt_status_i,
    output logic      [NUM_SRC-1:0] src_we_o,
    output apb_data_t               wdata_o,
    output logic                    evt_clear_o
);

    apb_state_t state_q;
    apb_state_t state_d;
    logic       access;
    logic       aligned;
    apb_addr_t  src_off;
    irq_id_t    src_idx;
    logic       src_hit;
    logic       evt_status_hit;
    logic       evt_clear_hit;
    logic       addr_err;
    logic       wr_en;

    //************************************************************************
    //***** APB phase tracking ***********************************************
    //************************************************************************

    always_comb begin
        state_d = state_q;
        case (state_q)
            APB_IDLE: begin
                // Setup cycle seen, the next cycle is the access cycle
                if (psel_i && !penable_i) begin
                    state_d = APB_ACCESS;
                end
            end
            APB_ACCESS: begin
                state_d = APB_IDLE;
            end
            default: begin
                state_d = APB_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= APB_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // No wait states, every access cycle completes
    assign access   = (state_q == APB_ACCESS) && psel_i && penable_i;
    assign pready_o = access;

    //************************************************************************
    //***** Address decode ***************************************************
    //************************************************************************

    assign aligned = (paddr_i[1:0] == 2'b00);

    // Offset wraps for addresses below the base, so one compare is enough
    assign src_off = paddr_i - REG_SRC_BASE;
    assign src_idx = src_off[2 +: $bits(irq_id_t)];
    assign src_hit = aligned && (src_off < apb_addr_t'(4 * NUM_SRC));

    assign evt_status_hit = (paddr_i == REG_EVT_STATUS);
    assign evt_clear_hit  = (paddr_i == REG_EVT_CLEAR);

    assign addr_err  = !(src_hit || evt_status_hit || evt_clear_hit);
    assign pslverr_o = access && addr_err;

    // Strobes last exactly one cycle, the access cycle
    assign wr_en       = access && pwrite_i && !addr_err;
    assign evt_clear_o = wr_en && evt_clear_hit;
    assign wdata_o     = pwdata_i;

    always_comb begin
        src_we_o = '0;
        if (wr_en && src_hit) begin
            src_we_o[src_idx] = 1'b1;
        end
    end

    // Read mux, the clear register and errors read as zero
    always_comb begin
        prdata_o = '0;
        if (src_hit) begin
            prdata_o = src_rdata_i[src_idx];
        end else if (evt_status_hit) begin
            prdata_o = evt_status_i;
        end
    end

endmodule

/* logic/irq_source_slice.sv */
module irq_source_slice
    import apb_defs_pkg::*;
    import irq_defs_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,

    // Level interrupt input
    input  logic       src_i,

    // Register access from the front end
    input  logic       cfg_we_i,
    input  apb_data_t  cfg_wdata_i,
    output apb_data_t  cfg_rdata_o,

    // Priority tree side
    input  logic       claim_i,
    output logic       req_o,
    output irq_level_t level_o
);

    logic       enable_q;
    logic       pending_q;
    irq_level_t level_q;
    logic       pending_clr;

    // Software clear is a write of 1 to bit 1
    assign pending_clr = claim_i || (cfg_we_i && cfg_wdata_i[1]);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            enable_q  <= 1'b0;
            level_q   <= '0;
            pending_q <= 1'b0;
        end else begin
            if (cfg_we_i) begin
                enable_q <= cfg_wdata_i[0];
                level_q  <= cfg_wdata_i[15:8];
            end
            // A source that is still high wins over any clear
            if (src_i && enable_q) begin
                pending_q <= 1'b1;
            end else if (pending_clr) begin
                pending_q <= 1'b0;
            end
        end
    end

    assign req_o   = pending_q && enable_q;
    assign level_o = level_q;

    // Level in bits 15..8, pending in bit 1, enable in bit 0
    assign cfg_rdata_o = {16'h0000, level_q, 6'b000000, pending_q, enable_q};

endmodule

/* logic/soc_event_to_level.sv */
module soc_event_to_level
    import apb_defs_pkg::*;
    import irq_defs_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,

    // SoC event stream
    input  logic      evt_valid_i,
    input  evt_id_t   evt_data_i,
    output logic      evt_ready_o,

    // Register side
    input  logic      clear_i,
    output apb_data_t status_o,

    // Level toward the source slice
    output logic      level_o
);

    logic    pending_q;
    logic    pending_d;
    logic    ready_q;
    logic    evt_take;
    evt_id_t evt_id_q;

    assign evt_take = evt_valid_i && ready_q;

    // A new event wins over a clear in the same cycle
    always_comb begin
        pending_d = pending_q;
        if (evt_take) begin
            pending_d = 1'b1;
        end else if (clear_i) begin
            pending_d = 1'b0;
        end
    end

    // Ready is registered so it stays low through reset
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pending_q <= 1'b0;
            ready_q   <= 1'b0;
            evt_id_q  <= '0;
        end else begin
            pending_q <= pending_d;
            ready_q   <= !pending_d;
            if (evt_take) begin
                evt_id_q <= evt_data_i;
            end
        end
    end

    assign evt_ready_o = ready_q;
    assign level_o     = pending_q;

    // Last identifier in bits 15..8, pending in bit 0
    assign status_o = {16'h0000, evt_id_q, 7'b0000000, pending_q};

endmodule

/* verification/fc_irq_props.sv */
module fc_irq_props
    import apb_defs_pkg::*;
    import irq_defs_pkg::*;
(
    input logic       clk_i,
    input logic       rst_i,
    input logic       psel_i,
    input logic       penable_i,
    input logic       pready_i,
    input logic       irq_valid_i,
    input logic       irq_ack_i,
    input irq_id_t    irq_id_i,
    input irq_level_t irq_level_i,
    input logic       evt_ready_i,
    input apb_data_t  evt_status_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // The offered request is frozen until the core takes it
    property request_stable;
        @(posedge clk_i) disable iff (rst_i)
        (irq_valid_i && !irq_ack_i) |=> ($stable(irq_id_i) && $stable(irq_level_i));
    endproperty

    // Ready only in the access cycle that follows a setup cycle
    property ready_in_access;
        @(posedge clk_i) disable iff (rst_i)
        pready_i |-> (psel_i && penable_i && $past(psel_i && !penable_i));
    endproperty

    // Back-pressure while an event is still pending
    property event_backpressure;
        @(posedge clk_i) disable iff (rst_i)
        evt_status_i[0] |-> !evt_ready_i;
    endproperty

    assert property (request_stable)
        else $error("irq_id_o or irq_level_o changed while the request was waiting");
    assert property (ready_in_access)
        else $error("pready_o was high outside an APB access cycle");
    assert property (event_backpressure)
        else $error("evt_ready_o was high while the event converter was pending");

endmodule

bind fc_irq_top fc_irq_props i_props (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .pready_i     (pready_o),
    .irq_valid_i  (irq_valid_o),
    .irq_ack_i    (irq_ack_i),
    .irq_id_i     (irq_id_o),
    .irq_level_i  (irq_level_o),
    .evt_ready_i  (evt_ready_o),
    .evt_status_i (evt_status)
);

/* verification/fc_irq_tb.sv */
module fc_irq_tb
    import apb_defs_pkg::*;
    import irq_defs_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT = 50;

    typedef enum logic [2:0] {
        OP_WRITE, OP_READ, OP_SRC, OP_EVENT, OP_ACK, OP_PINS
    } op_t;

    // One row of the stimulus table
    typedef struct packed {
        op_t       op;
        apb_addr_t addr;
        apb_data_t data;
        apb_data_t exp;
        logic      err;
    } step_t;

    logic               clk_i;
    logic               rst_i;
    apb_addr_t          paddr_i;
    logic               psel_i;
    logic               penable_i;
    logic               pwrite_i;
    apb_data_t          pwdata_i;
    apb_data_t          prdata_o;
    logic               pready_o;
    logic               pslverr_o;
    logic [NUM_SRC-1:0] irq_src_i;
    logic               evt_valid_i;
    evt_id_t            evt_data_i;
    logic               evt_ready_o;
    logic               irq_valid_o;
    irq_id_t            irq_id_o;
    irq_level_t         irq_level_o;
    logic               irq_ack_i;

    step_t steps[$];
    string names[$];
    int    check_errors;
    int    timeout_errors;

    fc_irq_top UUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    //************************************************************************
    //***** Compare tasks ****************************************************
    //************************************************************************

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        check_errors++;
        $display("CHECK FAILED %s: expected 0x%0h, actual 0x%0h", name, exp, act);
    endtask

    task automatic check_data(input string name, input apb_data_t exp, input apb_data_t act);
        if (act !== exp)
            report_mismatch(name, exp, act);
    endtask

    task automatic check_id(input string name, input irq_id_t exp, input irq_id_t act);
        if (act !== exp)
            report_mismatch(name, 32'(exp), 32'(act));
    endtask

    task automatic check_level(input string name, input irq_level_t exp, input irq_level_t act);
        if (act !== exp)
            report_mismatch(name, 32'(exp), 32'(act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
            report_mismatch(name, 32'(exp), 32'(act));
    endtask

    //************************************************************************
    //***** Stimulus *********************************************************
    //************************************************************************

    // Inputs change a short delay after the rising edge
    task automatic next_cycle();
        @(posedge clk_i);
        #10;
    endtask

    task automatic add_step(input op_t op, input apb_addr_t addr, input apb_data_t data,
                            input apb_data_t exp, input logic err, input string name);
        steps.push_back(step_t'{op, addr, data, exp, err});
        names.push_back(name);
    endtask

    // Polls at falling edges until evt_ready_o or irq_valid_o is high
    task automatic wait_until(input logic for_ready, input string name, output logic ok);
        int cycles;
        cycles = 0;
        @(negedge clk_i);
        while (!(for_ready ? evt_ready_o : irq_valid_o) && cycles < TIMEOUT) begin
            @(negedge clk_i);
            cycles++;
        end
        ok = for_ready ? evt_ready_o : irq_valid_o;
        if (!ok) begin
            timeout_errors++;
            $display("%s: timed out after %0d cycles waiting for %s", name, TIMEOUT,
                     for_ready ? "evt_ready_o" : "irq_valid_o");
        end
    endtask

    // Setup cycle, access cycle, then the bus goes idle again
    task automatic apb_access(input step_t s, input string name);
        next_cycle();
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = (s.op == OP_WRITE);
        paddr_i   = s.addr;
        pwdata_i  = s.data;
        next_cycle();
        penable_i = 1'b1;
        @(negedge clk_i);
        check_bit({name, " pready"}, 1'b1, pready_o);
        check_bit({name, " pslverr"}, s.err, pslverr_o);
        if (s.op == OP_READ)
            check_data(name, s.exp, prdata_o);
        next_cycle();
        psel_i    = 1'b0;
        penable_i = 1'b0;
    endtask

    task automatic run_step(input step_t s, input string name);
        logic ok;
        case (s.op)
            OP_WRITE, OP_READ: begin
                apb_access(s, name);
            end
            OP_SRC: begin
                next_cycle();
                irq_src_i = s.data[NUM_SRC-1:0];
            end
            OP_EVENT: begin
                next_cycle();
                evt_valid_i = 1'b1;
                evt_data_i  = s.data[7:0];
                wait_until(1'b1, name, ok);
                next_cycle();
                evt_valid_i = 1'b0;
            end
            OP_ACK: begin
                wait_until(1'b0, name, ok);
                if (ok) begin
                    check_id({name, " id"}, s.exp[3:0], irq_id_o);
                    check_level({name, " level"}, s.exp[15:8], irq_level_o);
                    next_cycle();
                    irq_ack_i = 1'b1;
                    next_cycle();
                    irq_ack_i = 1'b0;
                end
            end
            default: begin
                next_cycle();
                @(negedge clk_i);
                check_bit({name, " irq_valid"}, s.exp[0], irq_valid_o);
                check_bit({name, " evt_ready"}, s.exp[1], evt_ready_o);
            end
        endcase
    endtask

    // Columns are op, address, data or mask or event id, expected value, pslverr, name
    // OP_ACK expects the level in bits 15:8 and the id in bits 3:0
    // OP_PINS expects irq_valid_o in bit 0 and evt_ready_o in bit 1
    task automatic build_table();
        // Register access and bus errors
        // Bad addresses below alias slice 2 in their low bits
        add_step(OP_PINS,  12'h000, 32'h0, 32'h0000_0002, 1'b0, "after reset");
        add_step(OP_WRITE, 12'h008, 32'h0000_4201, 32'h0, 1'b0, "slice 2 write");
        add_step(OP_READ,  12'h008, 32'h0, 32'h0000_4201, 1'b0, "slice 2 read");
        add_step(OP_WRITE, 12'h00A, 32'h0000_FF00, 32'h0, 1'b1, "unaligned write");
        add_step(OP_READ,  12'h00A, 32'h0, 32'h0, 1'b1, "unaligned read");
        add_step(OP_READ,  12'h0C8, 32'h0, 32'h0, 1'b1, "unmapped read");
        add_step(OP_READ,  12'h008, 32'h0, 32'h0000_4201, 1'b0, "slice 2 unchanged");
        // Disabled source, then enabled
        add_step(OP_WRITE, 12'h00C, 32'h0000_3000, 32'h0, 1'b0, "slice 3 disabled");
        add_step(OP_SRC,   12'h000, 32'h0000_0008, 32'h0, 1'b0, "source 3 high");
        add_step(OP_READ,  12'h00C, 32'h0, 32'h0000_3000, 1'b0, "slice 3 idle");
        add_step(OP_PINS,  12'h000, 32'h0, 32'h0000_0002, 1'b0, "no request");
        add_step(OP_WRITE, 12'h00C, 32'h0000_3001, 32'h0, 1'b0, "slice 3 enable");
        add_step(OP_SRC,   12'h000, 32'h0, 32'h0, 1'b0, "source 3 low");
        add_step(OP_ACK,   12'h000, 32'h0, 32'h0000_3003, 1'b0, "source 3 request");
        // Delivery by falling level and by rising id on equal levels
        add_step(OP_WRITE, 12'h004, 32'h0000_2001, 32'h0, 1'b0, "slice 1 config");
        add_step(OP_WRITE, 12'h010, 32'h0000_6001, 32'h0, 1'b0, "slice 4 config");
        add_step(OP_WRITE, 12'h01C, 32'h0000_2001, 32'h0, 1'b0, "slice 7 config");
        add_step(OP_WRITE, 12'h024, 32'h0000_8001, 32'h0, 1'b0, "slice 9 config");
        add_step(OP_SRC,   12'h000, 32'h0000_0292, 32'h0, 1'b0, "four sources");
        add_step(OP_SRC,   12'h000, 32'h0, 32'h0, 1'b0, "four sources low");
        add_step(OP_ACK,   12'h000, 32'h0, 32'h0000_8009, 1'b0, "order first");
        add_step(OP_ACK,   12'h000, 32'h0, 32'h0000_6004, 1'b0, "order second");
        add_step(OP_ACK,   12'h000, 32'h0, 32'h0000_2001, 1'b0, "order third");
        add_step(OP_ACK,   12'h000, 32'h0, 32'h0000_2007, 1'b0, "order fourth");
        // SoC events on source 5
        add_step(OP_WRITE, 12'h014, 32'h0000_5001, 32'h0, 1'b0, "slice 5 config");
        add_step(OP_EVENT, 12'h000, 32'h0000_00A5, 32'h0, 1'b0, "event A5");
        add_step(OP_READ,  REG_EVT_STATUS, 32'h0, 32'h0000_A501, 1'b0, "status A5");
        add_step(OP_PINS,  12'h000, 32'h0, 32'h0000_0001, 1'b0, "event held");
        add_step(OP_WRITE, REG_EVT_CLEAR, 32'h0, 32'h0, 1'b0, "clear A5");
        add_step(OP_ACK,   12'h000, 32'h0, 32'h0000_5005, 1'b0, "event A5 request");
        add_step(OP_EVENT, 12'h000, 32'h0000_003C, 32'h0, 1'b0, "event 3C");
        add_step(OP_READ,  REG_EVT_STATUS, 32'h0, 32'h0000_3C01, 1'b0, "status 3C");
        add_step(OP_WRITE, REG_EVT_CLEAR, 32'h0, 32'h0, 1'b0, "clear 3C");
        add_step(OP_ACK,   12'h000, 32'h0, 32'h0000_5005, 1'b0, "event 3C request");
        // Software clear of a waiting request
        add_step(OP_WRITE, 12'h018, 32'h0000_7001, 32'h0, 1'b0, "slice 6 config");
        add_step(OP_SRC,   12'h000, 32'h0000_0240, 32'h0, 1'b0, "sources 6 and 9");
        add_step(OP_SRC,   12'h000, 32'h0, 32'h0, 1'b0, "sources 6 and 9 low");
        add_step(OP_WRITE, 12'h018, 32'h0000_7003, 32'h0, 1'b0, "slice 6 clear");
        add_step(OP_READ,  12'h018, 32'h0, 32'h0000_7001, 1'b0, "slice 6 cleared");
        add_step(OP_ACK,   12'h000, 32'h0, 32'h0000_8009, 1'b0, "only source 9");
        add_step(OP_PINS,  12'h000, 32'h0, 32'h0000_0002, 1'b0, "nothing left");
    endtask

    initial begin
        rst_i          = 1'b1;
        paddr_i        = '0;
        psel_i         = 1'b0;
        penable_i      = 1'b0;
        pwrite_i       = 1'b0;
        pwdata_i       = '0;
        irq_src_i      = '0;
        evt_valid_i    = 1'b0;
        evt_data_i     = '0;
        irq_ack_i      = 1'b0;
        check_errors   = 0;
        timeout_errors = 0;
        build_table();
        repeat (2) @(posedge clk_i);
        #10;
        rst_i = 1'b0;
        foreach (steps[i]) begin
            run_step(steps[i], names[i]);
        end
        $display("Errors: %0d failed checks, %0d timeouts", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
